/* Makefile */
TOP := tb_dmem_subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* common/dmem_cfg.svh */
`ifndef DMEM_CFG_SVH
`define DMEM_CFG_SVH

// Bus widths
`define DMEM_ADDR_W 32
`define DMEM_DATA_W 64
`define DMEM_TAG_W  8

// Depth in doublewords, indexed by address bits 12:3
`define DMEM_WORDS  1024

// Byte address of the first-level page table
`define PT_BASE     32'h0000_1000

`endif

/* common/dmem_pkg.sv */
`default_nettype none

`include "dmem_cfg.svh"

package dmem_pkg;

    typedef logic [`DMEM_ADDR_W-1:0] addr_t;
    typedef logic [`DMEM_DATA_W-1:0] data_t;
    typedef logic [`DMEM_TAG_W-1:0]  tag_t;
    typedef logic [19:0]             ppn_t;      // Physical page number

    typedef enum logic [4:0] {
        M_XRD = 5'b00000,                        // Load doubleword
        M_XWR = 5'b00001                         // Store doubleword
    } mem_cmd_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SERVING_PTW,
        ARB_SERVING_DP
    } arb_state_e;

    typedef enum logic [2:0] {
        PTW_IDLE,
        PTW_REQ_L1,
        PTW_WAIT_L1,
        PTW_REQ_L0,
        PTW_WAIT_L0,
        PTW_DONE
    } ptw_state_e;

    // Page table entry: bit 0 valid, bit 1 leaf, bits 29:10 PPN
    localparam int unsigned PTE_V_BIT    = 0;
    localparam int unsigned PTE_LEAF_BIT = 1;
    localparam int unsigned PTE_PPN_LSB  = 10;
    localparam int unsigned PTE_PPN_MSB  = 29;

endpackage

`default_nettype wire

/* compile.f */
+incdir+common
+incdir+tb
common/dmem_pkg.sv
dmem/dmem_latency_timer.sv
dmem/dmem_ram.sv
ptw/ptw_walker.sv
hdl/dmem_arbiter.sv
hdl/dmem_subsystem_top.sv
tb/tb_dmem_subsystem.sv

/* dmem/dmem_latency_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_latency_timer (
    input  wire logic       clk_i,
    input  wire logic       rstn_i,
    input  wire logic       start_i,
    input  wire logic [3:0] load_i,
    output logic            busy_o,
    output logic            done_o
);

    logic [3:0] count_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_o  <= 1'b0;
            count_q <= '0;
        end else if (start_i) begin
            busy_o  <= 1'b1;
            count_q <= load_i;
        end else if (busy_o) begin
            if (count_q == 4'd1) begin
                busy_o <= 1'b0;                          // Free after the done cycle
            end else begin
                count_q <= count_q - 4'd1;
            end
        end
    end

    assign done_o = busy_o && (count_q == 4'd1);

    a_no_restart: assert property (@(posedge clk_i) disable iff (!rstn_i)
        start_i |-> !busy_o && load_i != 4'd0)
        else $error("Timer restarted while busy or with zero latency");

endmodule

`default_nettype wire

/* dmem/dmem_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module dmem_ram import dmem_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rstn_i,
    input  wire logic     req_valid_i,
    input  wire mem_cmd_e req_cmd_i,
    input  wire addr_t    req_addr_i,
    input  wire data_t    req_data_i,
    input  wire tag_t     req_tag_i,
    output logic          req_ready_o,
    output logic          resp_valid_o,
    output data_t         resp_data_o,
    output tag_t          resp_tag_o,
    output logic          resp_has_data_o
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    data_t            mem_q [`DMEM_WORDS] = '{default: '0};
    mem_cmd_e         cmd_q;
    logic [IDX_W-1:0] idx_q;
    tag_t             tag_q;
    logic [IDX_W-1:0] req_idx;
    logic             req_fire;
    logic [3:0]       timer_load;
    logic             timer_busy;
    logic             timer_done;

    assign req_ready_o = !timer_busy;                    // One request in flight
    assign req_fire    = req_valid_i && req_ready_o;
    assign req_idx     = req_addr_i[IDX_W+2:3];          // Wraps at 8 KiB
    assign timer_load  = {1'b0, req_addr_i[5:3]} + 4'd1;

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            if (req_cmd_i == M_XWR) begin
                mem_q[req_idx] <= req_data_i;            // Stores land at accept
            end
            cmd_q <= req_cmd_i;
            idx_q <= req_idx;
            tag_q <= req_tag_i;
        end
    end

    assign resp_valid_o    = timer_done;
    assign resp_has_data_o = timer_done && (cmd_q == M_XRD);
    assign resp_data_o     = resp_has_data_o ? mem_q[idx_q] : '0;
    assign resp_tag_o      = timer_done ? tag_q : '0;

    dmem_latency_timer u_timer (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .start_i(req_fire),
        .load_i (timer_load),
        .busy_o (timer_busy),
        .done_o (timer_done)
    );

endmodule

`default_nettype wire

/* hdl/dmem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_arbiter import dmem_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rstn_i,
    // Datapath side
    input  wire logic     dp_req_valid_i,
    input  wire mem_cmd_e dp_req_cmd_i,
    input  wire addr_t    dp_req_addr_i,
    input  wire data_t    dp_req_data_i,
    input  wire tag_t     dp_req_tag_i,
    output logic          dp_req_ready_o,
    output logic          dp_resp_valid_o,
    output data_t         dp_resp_data_o,
    output tag_t          dp_resp_tag_o,
    output logic          dp_resp_has_data_o,
    // Walker side carries loads only
    input  wire logic     ptw_req_valid_i,
    input  wire addr_t    ptw_req_addr_i,
    output logic          ptw_req_ready_o,
    output logic          ptw_resp_valid_o,
    output data_t         ptw_resp_data_o,
    // Memory side
    output logic          mem_req_valid_o,
    output mem_cmd_e      mem_req_cmd_o,
    output addr_t         mem_req_addr_o,
    output data_t         mem_req_data_o,
    output tag_t          mem_req_tag_o,
    input  wire logic     mem_req_ready_i,
    input  wire logic     mem_resp_valid_i,
    input  wire data_t    mem_resp_data_i,
    input  wire tag_t     mem_resp_tag_i,
    input  wire logic     mem_resp_has_data_i
);

    arb_state_e state_q;
    arb_state_e state_d;
    logic       sel_dp;                          // Datapath owns the port
    logic       sel_ptw;                         // Walker owns the port
    logic       grant_dp;
    logic       grant_ptw;

    // Datapath wins in idle and a locked source keeps the port
    assign sel_dp  = (state_q == ARB_SERVING_DP) || (state_q == ARB_IDLE && dp_req_valid_i);
    assign sel_ptw = (state_q == ARB_SERVING_PTW) ||
                     (state_q == ARB_IDLE && !dp_req_valid_i && ptw_req_valid_i);

    assign dp_req_ready_o  = mem_req_ready_i && (state_q != ARB_SERVING_PTW);
    assign ptw_req_ready_o = mem_req_ready_i && (state_q == ARB_SERVING_PTW ||
                                                 (state_q == ARB_IDLE && !dp_req_valid_i));

    assign grant_dp  = dp_req_valid_i && dp_req_ready_o;
    assign grant_ptw = ptw_req_valid_i && ptw_req_ready_o;

    always_comb begin
        state_d = state_q;
        if (state_q == ARB_IDLE) begin
            if (grant_dp) begin
                state_d = ARB_SERVING_DP;                // Lock at the accept edge
            end else if (grant_ptw) begin
                state_d = ARB_SERVING_PTW;
            end
        end else if (mem_resp_valid_i) begin
            state_d = ARB_IDLE;                          // Release on the response
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Steer request and response fields so the idle source sees zeros
    always_comb begin
        mem_req_valid_o    = 1'b0;
        mem_req_cmd_o      = M_XRD;
        mem_req_addr_o     = '0;
        mem_req_data_o     = '0;
        mem_req_tag_o      = '0;
        dp_resp_valid_o    = 1'b0;
        dp_resp_data_o     = '0;
        dp_resp_tag_o      = '0;
        dp_resp_has_data_o = 1'b0;
        ptw_resp_valid_o   = 1'b0;
        ptw_resp_data_o    = '0;
        if (sel_dp) begin
            mem_req_valid_o    = dp_req_valid_i;
            mem_req_cmd_o      = dp_req_cmd_i;
            mem_req_addr_o     = dp_req_addr_i;
            mem_req_data_o     = dp_req_data_i;
            mem_req_tag_o      = dp_req_tag_i;
            dp_resp_valid_o    = mem_resp_valid_i;
            dp_resp_data_o     = mem_resp_data_i;
            dp_resp_tag_o      = mem_resp_tag_i;
            dp_resp_has_data_o = mem_resp_has_data_i;
        end else if (sel_ptw) begin
            mem_req_valid_o    = ptw_req_valid_i;    // Tag stays 0 for the walker
            mem_req_addr_o     = ptw_req_addr_i;
            ptw_resp_valid_o   = mem_resp_valid_i;
            ptw_resp_data_o    = mem_resp_data_i;
        end
    end

    a_grant_when_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (grant_dp || grant_ptw) |-> state_q == ARB_IDLE)
        else $error("Source granted while the port was locked");

endmodule

`default_nettype wire

/* hdl/dmem_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_subsystem_top import dmem_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rstn_i,
    input  wire logic     dp_req_valid_i,
    input  wire mem_cmd_e dp_req_cmd_i,
    input  wire addr_t    dp_req_addr_i,
    input  wire data_t    dp_req_data_i,
    input  wire tag_t     dp_req_tag_i,
    output logic          dp_req_ready_o,
    output logic          dp_resp_valid_o,
    output data_t         dp_resp_data_o,
    output tag_t          dp_resp_tag_o,
    output logic          dp_resp_has_data_o,
    input  wire logic     walk_req_i,
    input  wire addr_t    walk_vaddr_i,
    output logic          walk_busy_o,
    output logic          walk_done_o,
    output ppn_t          walk_ppn_o,
    output logic          walk_fault_o,
    output logic          walk_superpage_o
);

    logic     ptw_req_valid;
    addr_t    ptw_req_addr;
    logic     ptw_req_ready;
    logic     ptw_resp_valid;
    data_t    ptw_resp_data;
    logic     mem_req_valid;
    mem_cmd_e mem_req_cmd;
    addr_t    mem_req_addr;
    data_t    mem_req_data;
    tag_t     mem_req_tag;
    logic     mem_req_ready;
    logic     mem_resp_valid;
    data_t    mem_resp_data;
    tag_t     mem_resp_tag;
    logic     mem_resp_has_data;

    ptw_walker u_walker (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .walk_req_i(walk_req_i), .walk_vaddr_i(walk_vaddr_i),
        .walk_busy_o(walk_busy_o), .walk_done_o(walk_done_o), .walk_ppn_o(walk_ppn_o),
        .walk_fault_o(walk_fault_o), .walk_superpage_o(walk_superpage_o),
        .mem_req_valid_o(ptw_req_valid), .mem_req_addr_o(ptw_req_addr),
        .mem_req_ready_i(ptw_req_ready), .mem_resp_valid_i(ptw_resp_valid),
        .mem_resp_data_i(ptw_resp_data)
    );

    dmem_arbiter u_arbiter (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .dp_req_valid_i(dp_req_valid_i), .dp_req_cmd_i(dp_req_cmd_i),
        .dp_req_addr_i(dp_req_addr_i), .dp_req_data_i(dp_req_data_i),
        .dp_req_tag_i(dp_req_tag_i), .dp_req_ready_o(dp_req_ready_o),
        .dp_resp_valid_o(dp_resp_valid_o), .dp_resp_data_o(dp_resp_data_o),
        .dp_resp_tag_o(dp_resp_tag_o), .dp_resp_has_data_o(dp_resp_has_data_o),
        .ptw_req_valid_i(ptw_req_valid), .ptw_req_addr_i(ptw_req_addr),
        .ptw_req_ready_o(ptw_req_ready), .ptw_resp_valid_o(ptw_resp_valid),
        .ptw_resp_data_o(ptw_resp_data),
        .mem_req_valid_o(mem_req_valid), .mem_req_cmd_o(mem_req_cmd),
        .mem_req_addr_o(mem_req_addr), .mem_req_data_o(mem_req_data),
        .mem_req_tag_o(mem_req_tag), .mem_req_ready_i(mem_req_ready),
        .mem_resp_valid_i(mem_resp_valid), .mem_resp_data_i(mem_resp_data),
        .mem_resp_tag_i(mem_resp_tag), .mem_resp_has_data_i(mem_resp_has_data)
    );

    dmem_ram u_ram (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .req_valid_i(mem_req_valid), .req_cmd_i(mem_req_cmd), .req_addr_i(mem_req_addr),
        .req_data_i(mem_req_data), .req_tag_i(mem_req_tag), .req_ready_o(mem_req_ready),
        .resp_valid_o(mem_resp_valid), .resp_data_o(mem_resp_data),
        .resp_tag_o(mem_resp_tag), .resp_has_data_o(mem_resp_has_data)
    );

endmodule

`default_nettype wire

/* ptw/ptw_walker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module ptw_walker import dmem_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rstn_i,
    input  wire logic  walk_req_i,
    input  wire addr_t walk_vaddr_i,
    output logic       walk_busy_o,
    output logic       walk_done_o,
    output ppn_t       walk_ppn_o,
    output logic       walk_fault_o,
    output logic       walk_superpage_o,
    output logic       mem_req_valid_o,
    output addr_t      mem_req_addr_o,
    input  wire logic  mem_req_ready_i,
    input  wire logic  mem_resp_valid_i,
    input  wire data_t mem_resp_data_i
);

    ptw_state_e state_q;
    ptw_state_e state_d;
    addr_t      vaddr_q;
    ppn_t       table_ppn_q;                     // Second-level table page
    logic       pte_valid;
    logic       pte_leaf;
    ppn_t       pte_ppn;

    assign pte_valid = mem_resp_data_i[PTE_V_BIT];
    assign pte_leaf  = mem_resp_data_i[PTE_LEAF_BIT];
    assign pte_ppn   = mem_resp_data_i[PTE_PPN_MSB:PTE_PPN_LSB];

    assign walk_busy_o     = (state_q != PTW_IDLE);
    assign walk_done_o     = (state_q == PTW_DONE);
    assign mem_req_valid_o = (state_q == PTW_REQ_L1) || (state_q == PTW_REQ_L0);

    // L1 entry at PT_BASE + vpn1*8 and L0 entry at ppn*4096 + vpn0*8
    assign mem_req_addr_o = (state_q == PTW_REQ_L0) ?
        {table_ppn_q, 12'h000} + {19'b0, vaddr_q[21:12], 3'b000} :
        addr_t'(`PT_BASE) + {19'b0, vaddr_q[31:22], 3'b000};

    always_comb begin
        state_d = state_q;
        case (state_q)
            PTW_IDLE:    if (walk_req_i) state_d = PTW_REQ_L1;
            PTW_REQ_L1:  if (mem_req_ready_i) state_d = PTW_WAIT_L1;
            PTW_WAIT_L1: begin
                if (mem_resp_valid_i) begin
                    // Invalid or leaf entry ends the walk early
                    state_d = (!pte_valid || pte_leaf) ? PTW_DONE : PTW_REQ_L0;
                end
            end
            PTW_REQ_L0:  if (mem_req_ready_i) state_d = PTW_WAIT_L0;
            PTW_WAIT_L0: if (mem_resp_valid_i) state_d = PTW_DONE;
            default:     state_d = PTW_IDLE;                 // DONE lasts one cycle
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= PTW_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == PTW_IDLE && walk_req_i) begin
            vaddr_q <= walk_vaddr_i;
        end
        if (state_q == PTW_WAIT_L1 && mem_resp_valid_i) begin
            table_ppn_q      <= pte_ppn;
            walk_ppn_o       <= pte_ppn;
            walk_fault_o     <= !pte_valid;
            walk_superpage_o <= pte_valid && pte_leaf;   // Megapage hit
        end
        if (state_q == PTW_WAIT_L0 && mem_resp_valid_i) begin
            walk_ppn_o       <= pte_ppn;
            walk_fault_o     <= !(pte_valid && pte_leaf);
            walk_superpage_o <= 1'b0;
        end
    end

    a_resp_when_waiting: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_resp_valid_i |-> (state_q == PTW_WAIT_L1 || state_q == PTW_WAIT_L0))
        else $error("Memory response while the walker was not waiting");

endmodule

`default_nettype wire

/* tb/tb_dmem_checks.svh */
`ifndef TB_DMEM_CHECKS_SVH
`define TB_DMEM_CHECKS_SVH

localparam int WAIT_LIMIT = 50;                          // Cycles allowed per wait

task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
        abort_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp) begin
        abort_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic check_ppn(input string name, input ppn_t got, input ppn_t exp);
    if (got !== exp) begin
        abort_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp));
    end
endtask

// All waits poll on falling edges, the current edge first
task automatic wait_dp_ready();
    for (int n = 0; dp_req_ready_o !== 1'b1; n++) begin
        if (n == WAIT_LIMIT) abort_run("Datapath request was never accepted");
        @(negedge clk_i);
    end
endtask

task automatic wait_dp_resp();
    for (int n = 0; dp_resp_valid_o !== 1'b1; n++) begin
        if (n == WAIT_LIMIT) abort_run("No datapath response arrived in time");
        @(negedge clk_i);
    end
endtask

task automatic wait_walk_done();
    for (int n = 0; walk_done_o !== 1'b1; n++) begin
        if (n == WAIT_LIMIT) abort_run("Page table walk did not finish in time");
        @(negedge clk_i);
    end
endtask

`endif

/* tb/tb_dmem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module tb_dmem_subsystem import dmem_pkg::*; ();

    logic        clk_i;
    logic        rstn_i;
    logic        dp_req_valid_i;
    mem_cmd_e    dp_req_cmd_i;
    addr_t       dp_req_addr_i;
    data_t       dp_req_data_i;
    tag_t        dp_req_tag_i;
    logic        dp_req_ready_o;
    logic        dp_resp_valid_o;
    data_t       dp_resp_data_o;
    tag_t        dp_resp_tag_o;
    logic        dp_resp_has_data_o;
    logic        walk_req_i;
    addr_t       walk_vaddr_i;
    logic        walk_busy_o;
    logic        walk_done_o;
    ppn_t        walk_ppn_o;
    logic        walk_fault_o;
    logic        walk_superpage_o;
    data_t       model_mem [`DMEM_WORDS];                // Reference copy of the array
    logic [31:0] lcg_state;

    dmem_subsystem_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    `include "tb_dmem_checks.svh"

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);            // Fold high bits down
    endfunction

    // Doubleword index wraps every address at 8 KiB
    function automatic logic [9:0] word_index(input addr_t a);
        return a[12:3];
    endfunction

    // 64 words below the tables with random upper bits to exercise the wrap
    function automatic addr_t rand_addr();
        logic [31:0] r;
        r = next_rand();
        return {r[31:13], 4'b0000, r[8:3], 3'b000};
    endfunction

    function automatic addr_t l1_addr(input addr_t va);
        return `PT_BASE + {19'b0, va[31:22], 3'b000};
    endfunction

    function automatic addr_t l0_addr(input ppn_t tbl, input addr_t va);
        return {tbl, 12'h000} + {19'b0, va[21:12], 3'b000};
    endfunction

    function automatic data_t make_pte(input ppn_t ppn, input logic v, input logic leaf);
        return {34'b0, ppn, 8'b0, leaf, v};
    endfunction

    // Reference two-level walk over the model array
    task automatic model_walk(input addr_t va, output ppn_t ppn, output logic fault,
                              output logic is_super);
        data_t pte;
        pte      = model_mem[word_index(l1_addr(va))];
        ppn      = pte[29:10];
        fault    = !pte[0];
        is_super = pte[0] && pte[1];
        if (pte[0] && !pte[1]) begin
            pte      = model_mem[word_index(l0_addr(pte[29:10], va))];
            ppn      = pte[29:10];
            fault    = !(pte[0] && pte[1]);
            is_super = 1'b0;
        end
    endtask

    task automatic dp_access(input mem_cmd_e cmd, input addr_t addr, input data_t wdata);
        tag_t  tag;
        data_t expect_rd;
        tag            = tag_t'(next_rand() >> 8);
        dp_req_valid_i = 1'b1;
        dp_req_cmd_i   = cmd;
        dp_req_addr_i  = addr;
        dp_req_data_i  = wdata;
        dp_req_tag_i   = tag;
        wait_dp_ready();                                 // Taken at the next rising edge
        expect_rd = model_mem[word_index(addr)];
        if (cmd == M_XWR) begin
            model_mem[word_index(addr)] = wdata;
        end
        @(negedge clk_i);
        dp_req_valid_i = 1'b0;
        wait_dp_resp();
        check_tag("dp_resp_tag_o", dp_resp_tag_o, tag);
        check_flag("dp_resp_has_data_o", dp_resp_has_data_o, cmd == M_XRD);
        if (cmd == M_XRD) begin
            check_data("dp_resp_data_o", dp_resp_data_o, expect_rd);
        end
        repeat (2) @(negedge clk_i);                     // Idle edge lets the walker in
    endtask

    task automatic random_access();
        logic [31:0] r;
        r = next_rand();
        dp_access(r[4] ? M_XWR : M_XRD, rand_addr(), {next_rand(), next_rand()});
    endtask

    task automatic run_walk(input addr_t va);
        ppn_t exp_ppn;
        logic exp_fault;
        logic exp_super;
        model_walk(va, exp_ppn, exp_fault, exp_super);
        check_flag("walk_busy_o", walk_busy_o, 1'b0);
        walk_req_i   = 1'b1;
        walk_vaddr_i = va;
        @(negedge clk_i);
        walk_req_i = 1'b0;
        wait_walk_done();
        check_flag("walk_fault_o", walk_fault_o, exp_fault);
        if (!exp_fault) begin
            check_flag("walk_superpage_o", walk_superpage_o, exp_super);
            check_ppn("walk_ppn_o", walk_ppn_o, exp_ppn);
        end
        @(negedge clk_i);
        check_flag("walk_done_o", walk_done_o, 1'b0);   // One-cycle pulse
    endtask

    // Both entries land in the upper half of the array away from random traffic
    task automatic walk_case(input logic l1_v, input logic l1_leaf, input logic l0_v,
                             input logic l0_leaf, input logic with_traffic);
        addr_t va;
        ppn_t  tbl;
        ppn_t  leaf_ppn;
        va       = next_rand() & 32'h7fff_ffff;          // vpn1 below 512
        tbl      = ppn_t'(next_rand()) | 20'h1;          // Odd table page
        leaf_ppn = ppn_t'(next_rand() >> 12);
        if (va[31:22] == va[21:12]) begin
            va[12] = ~va[12];                            // Keep the two entries apart
        end
        dp_access(M_XWR, l1_addr(va), make_pte(l1_leaf ? leaf_ppn : tbl, l1_v, l1_leaf));
        dp_access(M_XWR, l0_addr(tbl, va), make_pte(leaf_ppn ^ 20'h5a5a5, l0_v, l0_leaf));
        if (with_traffic) begin
            fork
                run_walk(va);
                repeat (8) random_access();
            join
        end else begin
            run_walk(va);
        end
    endtask

    initial begin
        lcg_state      = 32'h1cc9;
        rstn_i         = 1'b0;
        dp_req_valid_i = 1'b0;
        dp_req_cmd_i   = M_XRD;
        dp_req_addr_i  = '0;
        dp_req_data_i  = '0;
        dp_req_tag_i   = '0;
        walk_req_i     = 1'b0;
        walk_vaddr_i   = '0;
        model_mem      = '{default: '0};
        repeat (3) @(negedge clk_i);
        rstn_i = 1'b1;
        check_flag("dp_resp_valid_o", dp_resp_valid_o, 1'b0);
        check_flag("walk_busy_o", walk_busy_o, 1'b0);
        check_flag("walk_done_o", walk_done_o, 1'b0);
        wait_dp_ready();
        repeat (200) random_access();
        walk_case(1'b1, 1'b0, 1'b1, 1'b1, 1'b0);        // Two-level translation
        walk_case(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);        // Superpage
        walk_case(1'b0, 1'b0, 1'b1, 1'b1, 1'b0);        // Invalid first level
        walk_case(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);        // Invalid second level
        walk_case(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);        // Pointer at the second level
        repeat (6) begin
            walk_case(1'b1, 1'b0, 1'b1, 1'b1, 1'b1);    // Walk under datapath load
        end
        walk_case(1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
